//--- serdes_apb_bridge.f
+incdir+design
design/bridge_pkg.sv
design/lane_pkg.sv
design/lane_crc.sv
design/frame_tx.sv
design/frame_rx.sv
design/bridge_ctrl.sv
design/serdes_apb_bridge.sv
tests/serdes_apb_bridge_tb.sv

//--- Bender.yml
package:
  name: serdes_apb_bridge

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/bridge_pkg.sv
      - design/lane_pkg.sv
      - design/lane_crc.sv
      - design/frame_tx.sv
      - design/frame_rx.sv
      - design/bridge_ctrl.sv
      - design/serdes_apb_bridge.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/serdes_apb_bridge_tb.sv

//--- tests/serdes_apb_bridge_tb.sv
`timescale 1ns/1ps
`include "bridge_macros.svh"

module serdes_apb_bridge_tb import bridge_pkg::*; ();

	localparam int CLK_PERIOD      = 40;
	localparam int NUM_TESTS       = 5;
	localparam int CYCLES_PER_TEST = 200;

	//Far end behavior for read frames
	localparam int MODE_NORMAL = 0;
	localparam int MODE_ERR    = 1;	//Status RESP_ERR
	localparam int MODE_BADCRC = 2;	//CRC byte inverted
	localparam int MODE_SILENT = 3;	//No response at all
	localparam int MODE_DROP   = 4;	//Alignment lost on data word

	logic                          sysclk;
	logic                          rst;
	logic                          psel;
	logic                          penable;
	logic                          pwrite;
	logic [`BRIDGE_ADDR_WIDTH-1:0] paddr;
	logic [`BRIDGE_DATA_WIDTH-1:0] pwdata;
	logic [`BRIDGE_DATA_WIDTH-1:0] prdata;
	logic                          pready;
	logic                          pslverr;
	logic [`BRIDGE_DATA_WIDTH-1:0] tx_data;
	logic [`LANE_K_WIDTH-1:0]      tx_char_is_k;
	logic [`BRIDGE_DATA_WIDTH-1:0] rx_data;
	logic [`LANE_K_WIDTH-1:0]      rx_char_is_k;
	logic                          rx_comma_is_aligned;
	logic                          link_up;

	integer       seed;
	string        test_name;
	int           far_mode;
	resp_status_t decoded_status;	//Last status frame_rx decoded
	logic         link_low_seen;

	////////////////////////////////////////////////////////////
	// Far end model state

	logic [31:0] far_mem [0:1023];
	logic [36:0] rx_q[$];			//{drop align, K flags, word}
	apb_op_t     cap_op_q[$];
	logic [9:0]  cap_addr_q[$];
	logic [31:0] cap_data_q[$];
	logic [7:0]  cap_crc_q[$];
	logic [1:0]  cap_pos;			//0 hunt, 1 data, 2 EOF
	logic [31:0] cap_sof;
	logic [31:0] cap_data;
	logic [7:0]  resp_code;
	logic [7:0]  resp_crc;
	logic [31:0] resp_word;

	serdes_apb_bridge UUT (
		.sysclk(sysclk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr),
		.tx_data(tx_data), .tx_char_is_k(tx_char_is_k),
		.rx_data(rx_data), .rx_char_is_k(rx_char_is_k),
		.rx_comma_is_aligned(rx_comma_is_aligned),
		.link_up(link_up)
	);

	always #(CLK_PERIOD / 2) sysclk = ~sysclk;

	//Poly 07, init 00, bytes LSB first, SOF K byte as zero
	function automatic logic [7:0] crc_of_frame(input logic [7:0] code, input logic [9:0] addr,
		input logic [31:0] data);
		logic [63:0] msg;
		logic [7:0]  c;
		msg = {data, 6'b0, addr, code, 8'h00};
		c   = 8'h00;
		for (int n = 0; n < 8; n++) begin
			c = c ^ msg[8*n +: 8];
			for (int b = 0; b < 8; b++)
				c = c[7] ? ({c[6:0], 1'b0} ^ 8'h07) : {c[6:0], 1'b0};
		end
		return c;
	endfunction

	function automatic logic [31:0] fill_word(input logic [9:0] a);
		return {~a, 6'h15, a, 6'h2a};	//Every address bit shows twice
	endfunction

	task abort_run(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "stopped at %0t ns", $time);
	endtask

	////////////////////////////////////////////////////////////
	// Compare tasks

	task check_word(input logic [31:0] exp, input logic [31:0] act, input string what);
		if (act !== exp)
			abort_run($sformatf("** Error %s %s: expected %h, actual %h", test_name, what, exp, act));
	endtask

	task check_flag(input logic exp, input logic act, input string what);
		if (act !== exp)
			abort_run($sformatf("** Error %s %s: expected %b, actual %b", test_name, what, exp, act));
	endtask

	task check_op(input apb_op_t exp, input apb_op_t act, input string what);
		if (act !== exp)
			abort_run($sformatf("** Error %s %s: expected %s, actual %h", test_name, what,
				exp.name(), act));
	endtask

	task check_status(input resp_status_t exp, input resp_status_t act, input string what);
		if (act !== exp)
			abort_run($sformatf("** Error %s %s: expected %s, actual %h", test_name, what,
				exp.name(), act));
	endtask

	////////////////////////////////////////////////////////////
	// Far end, captures frames and drives the receive lane

	task serve_frame;
		cap_op_q.push_back(apb_op_t'(cap_sof[15:8]));
		cap_addr_q.push_back(cap_sof[25:16]);
		cap_data_q.push_back(cap_data);
		cap_crc_q.push_back(tx_data[15:8]);
		if (cap_sof[15:8] == OP_WRITE)
			far_mem[cap_sof[25:16]] = cap_data;
		else if (far_mode != MODE_SILENT) begin
			resp_code = (far_mode == MODE_ERR) ? RESP_ERR : RESP_OK;
			resp_word = far_mem[cap_sof[25:16]];
			resp_crc  = crc_of_frame(resp_code, cap_sof[25:16], resp_word);
			if (far_mode == MODE_BADCRC)
				resp_crc = ~resp_crc;
			rx_q.push_back({1'b0, `LANE_K_CTRL, 6'b0, cap_sof[25:16], resp_code, `LANE_K_SOF});
			rx_q.push_back({far_mode == MODE_DROP, 4'b0000, resp_word});
			rx_q.push_back({1'b0, `LANE_K_CTRL, 16'h0000, resp_crc, `LANE_K_EOF});
		end
	endtask

	always @(posedge sysclk) begin
		if (!rst && !link_up)
			link_low_seen = 1'b1;
		if (!rst && UUT.resp_valid)
			decoded_status = UUT.resp_status;	//Response as frame_rx saw it
		if (rst)
			cap_pos = 2'd0;
		else begin
			case (cap_pos)
				2'd0: begin
					if (tx_char_is_k == `LANE_K_CTRL && tx_data[7:0] == `LANE_K_SOF) begin
						cap_sof = tx_data;
						cap_pos = 2'd1;
					end
				end
				2'd1: begin
					cap_data = tx_data;
					cap_pos  = 2'd2;
				end
				default: begin
					cap_pos = 2'd0;
					if (tx_char_is_k == `LANE_K_CTRL && tx_data[7:0] == `LANE_K_EOF)
						serve_frame();
				end
			endcase
		end
		if (rx_q.size() > 0) begin	//Queued words first, idle otherwise
			rx_data             <= rx_q[0][31:0];
			rx_char_is_k        <= rx_q[0][35:32];
			rx_comma_is_aligned <= !rx_q[0][36];
			void'(rx_q.pop_front());
		end else begin
			rx_data             <= `LANE_IDLE_WORD;
			rx_char_is_k        <= `LANE_K_CTRL;
			rx_comma_is_aligned <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Bus and lane helpers

	task automatic apb_xfer(input logic wr, input logic [9:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge sysclk);
		psel    <= 1'b1;	//Setup phase
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge sysclk);
		penable <= 1'b1;
		@(posedge sysclk);
		while (!pready)
			@(posedge sysclk);
		rdata = prdata;
		err   = pslverr;
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	//Queued between edges so the lane driver never races it
	task automatic grant_credits(input int n);
		@(negedge sysclk);
		rx_q.push_back({1'b0, `LANE_K_CTRL, 16'h0000, 8'(n), `LANE_K_CREDIT});
		while (rx_q.size() != 0)
			@(posedge sysclk);
		repeat (3) @(posedge sysclk);	//Lane word, credit_valid, counter
	endtask

	task automatic wait_frames(input int n);
		int waited;
		waited = 0;
		while (cap_op_q.size() < n && waited < 20) begin
			@(posedge sysclk);
			waited++;
		end
		if (cap_op_q.size() < n)
			abort_run($sformatf("%s: request frame %0d never reached the far end", test_name, n));
	endtask

	task automatic wait_link(input int limit);
		int waited;
		waited = 0;
		while (!link_up && waited < limit) begin
			@(posedge sysclk);
			waited++;
		end
		if (!link_up)
			abort_run($sformatf("%s: link_up did not rise on idle commas", test_name));
	endtask

	task clear_captures;
		cap_op_q.delete();
		cap_addr_q.delete();
		cap_data_q.delete();
		cap_crc_q.delete();
	endtask

	task automatic check_frame(input int i, input apb_op_t op, input logic [9:0] addr,
		input logic [31:0] data);
		check_op(op, cap_op_q[i], "frame opcode");
		check_word({22'b0, addr}, {22'b0, cap_addr_q[i]}, "frame address");
		check_word(data, cap_data_q[i], "frame data");
		check_word({24'b0, crc_of_frame(op, addr, data)}, {24'b0, cap_crc_q[i]}, "frame crc");
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_reset_idle;
		test_name = "reset_idle";
		@(posedge sysclk);	//First edge out of reset
		check_word(`LANE_IDLE_WORD, tx_data, "tx_data");
		check_word({28'b0, `LANE_K_CTRL}, {28'b0, tx_char_is_k}, "tx_char_is_k");
		check_flag(1'b0, pready, "pready");
		check_flag(1'b0, link_up, "link_up");
		wait_link(10);
	endtask

	task automatic test_posted_writes;
		logic [9:0]  addr [5];
		logic [31:0] data [5];
		logic [31:0] rdata;
		logic        err;
		test_name = "posted_writes";
		clear_captures();
		grant_credits(4);
		for (int i = 0; i < 5; i++) begin
			addr[i] = 10'($random(seed));
			data[i] = $random(seed);
		end
		for (int i = 0; i < 4; i++) begin
			apb_xfer(1'b1, addr[i], data[i], rdata, err);
			check_flag(1'b0, err, "pslverr");
		end
		wait_frames(4);
		for (int i = 0; i < 4; i++)
			check_frame(i, OP_WRITE, addr[i], data[i]);
		fork
			begin
				apb_xfer(1'b1, addr[4], data[4], rdata, err);
				check_flag(1'b0, err, "pslverr");
			end
			begin	//Out of credits, access phase must hold
				repeat (30) begin
					@(posedge sysclk);
					if (pready)
						abort_run("posted_writes: fifth write completed with no credit left");
				end
				if (cap_op_q.size() != 4)
					abort_run("posted_writes: a frame left without a credit");
				grant_credits(1);
			end
		join
		wait_frames(5);
		check_frame(4, OP_WRITE, addr[4], data[4]);
	endtask

	task automatic test_read_back;
		logic [9:0]  addr [4];
		logic [31:0] data [4];
		logic [31:0] rnd;
		logic [31:0] rdata;
		logic        err;
		test_name = "read_back";
		clear_captures();
		grant_credits(4);
		for (int i = 0; i < 4; i++) begin
			rnd     = $random(seed);
			addr[i] = {rnd[5:0], 4'b0} | 10'(i);	//Low bits keep addresses apart
			data[i] = $random(seed);
			apb_xfer(1'b1, addr[i], data[i], rdata, err);
		end
		wait_frames(4);
		clear_captures();
		grant_credits(4);
		for (int i = 0; i < 4; i++) begin
			apb_xfer(1'b0, addr[i], 32'h0, rdata, err);
			check_flag(1'b0, err, "pslverr");
			check_word(data[i], rdata, "prdata");
			check_status(RESP_OK, decoded_status, "decoded status");
			check_frame(i, OP_READ, addr[i], 32'h0);	//Read frames carry zero data
		end
	endtask

	task automatic test_error_paths;
		logic [31:0] rdata;
		logic        err;
		test_name = "error_paths";
		grant_credits(4);
		far_mode = MODE_ERR;
		apb_xfer(1'b0, 10'h155, 32'h0, rdata, err);
		check_flag(1'b1, err, "pslverr on RESP_ERR");
		check_status(RESP_ERR, decoded_status, "decoded status");
		far_mode = MODE_BADCRC;
		apb_xfer(1'b0, 10'h2aa, 32'h0, rdata, err);
		check_flag(1'b1, err, "pslverr on bad crc");
		check_word(32'h0, rdata, "prdata on bad crc");
		check_status(RESP_CRC, decoded_status, "decoded status");
		far_mode = MODE_NORMAL;	//Good read puts live data on prdata
		apb_xfer(1'b0, 10'h0f0, 32'h0, rdata, err);
		check_flag(1'b0, err, "pslverr before timeout");
		check_word(far_mem[10'h0f0], rdata, "prdata before timeout");
		far_mode = MODE_SILENT;
		apb_xfer(1'b0, 10'h0f0, 32'h0, rdata, err);
		check_flag(1'b1, err, "pslverr on timeout");
		check_word(32'h0, rdata, "prdata on timeout");
		far_mode = MODE_NORMAL;
	endtask

	task automatic test_align_loss;
		logic [31:0] rdata;
		logic        err;
		test_name = "align_loss";
		grant_credits(2);
		check_flag(1'b1, link_up, "link_up before drop");
		apb_xfer(1'b0, 10'h3c3, 32'h0, rdata, err);	//Live data on prdata first
		check_flag(1'b0, err, "pslverr before drop");
		check_word(far_mem[10'h3c3], rdata, "prdata before drop");
		link_low_seen = 1'b0;
		far_mode      = MODE_DROP;
		apb_xfer(1'b0, 10'h3c3, 32'h0, rdata, err);
		far_mode      = MODE_NORMAL;
		if (!link_low_seen)
			abort_run("align_loss: link_up stayed high while alignment was lost");
		check_flag(1'b1, err, "pslverr after drop");
		check_word(32'h0, rdata, "prdata after drop");
		wait_link(10);
	endtask

	////////////////////////////////////////////////////////////
	// Sequence and watchdog

	initial begin
		seed                = 32'h6eaf_595b;
		far_mode            = MODE_NORMAL;
		decoded_status      = RESP_OK;
		link_low_seen       = 1'b0;
		cap_pos             = 2'd0;
		sysclk              = 1'b0;
		rst                 = 1'b1;
		psel                = 1'b0;
		penable             = 1'b0;
		pwrite              = 1'b0;
		paddr               = '0;
		pwdata              = '0;
		rx_data             = `LANE_IDLE_WORD;
		rx_char_is_k        = `LANE_K_CTRL;
		rx_comma_is_aligned = 1'b1;
		for (int a = 0; a < 1024; a++)
			far_mem[a] = fill_word(10'(a));
		repeat (4) @(posedge sysclk);
		rst <= 1'b0;
		test_reset_idle();
		test_posted_writes();
		test_read_back();
		test_error_paths();
		test_align_loss();
		repeat (5) @(posedge sysclk);
		$display("** PASS **");
		$finish;
	end

	initial begin
		#(CLK_PERIOD * (CYCLES_PER_TEST * NUM_TESTS + 1000));
		abort_run($sformatf("Watchdog expired during %s, the DUT stopped responding", test_name));
	end

endmodule

//--- design/serdes_apb_bridge.sv
`timescale 1ns/1ps
`include "bridge_macros.svh"

module serdes_apb_bridge import bridge_pkg::*; (
	input  logic                           sysclk,
	input  logic                           rst,

	//APB from local manager
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [`BRIDGE_ADDR_WIDTH-1:0]  paddr,
	input  logic [`BRIDGE_DATA_WIDTH-1:0]  pwdata,
	output logic [`BRIDGE_DATA_WIDTH-1:0]  prdata,
	output logic                           pready,
	output logic                           pslverr,

	//Lane, 32 bit parallel side
	output logic [`BRIDGE_DATA_WIDTH-1:0]  tx_data,
	output logic [`LANE_K_WIDTH-1:0]       tx_char_is_k,
	input  logic [`BRIDGE_DATA_WIDTH-1:0]  rx_data,
	input  logic [`LANE_K_WIDTH-1:0]       rx_char_is_k,
	input  logic                           rx_comma_is_aligned,
	output logic                           link_up
);

	////////////////////////////////////////////////////////////
	// Control to datapath

	logic                            tx_start;
	apb_op_t                         tx_op;
	logic [`BRIDGE_ADDR_WIDTH-1:0]   tx_addr;
	logic [`BRIDGE_DATA_WIDTH-1:0]   tx_wdata;
	logic                            tx_busy;
	logic                            resp_valid;
	resp_status_t                    resp_status;
	logic [`BRIDGE_DATA_WIDTH-1:0]   resp_rdata;
	logic                            credit_valid;
	logic [`BRIDGE_CREDIT_WIDTH-1:0] credit_count;

	bridge_ctrl ctrl (
		.sysclk(sysclk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr),
		.tx_start(tx_start), .tx_op(tx_op), .tx_addr(tx_addr),
		.tx_wdata(tx_wdata), .tx_busy(tx_busy),
		.resp_valid(resp_valid), .resp_status(resp_status), .resp_rdata(resp_rdata),
		.credit_valid(credit_valid), .credit_count(credit_count)
	);

	////////////////////////////////////////////////////////////
	// Lane datapath

	frame_tx tx (
		.sysclk(sysclk), .rst(rst),
		.tx_start(tx_start), .tx_op(tx_op), .tx_addr(tx_addr), .tx_wdata(tx_wdata),
		.tx_busy(tx_busy), .tx_data(tx_data), .tx_char_is_k(tx_char_is_k)
	);

	frame_rx rx (
		.sysclk(sysclk), .rst(rst),
		.rx_data(rx_data), .rx_char_is_k(rx_char_is_k),
		.rx_comma_is_aligned(rx_comma_is_aligned),
		.resp_valid(resp_valid), .resp_status(resp_status), .resp_rdata(resp_rdata),
		.credit_valid(credit_valid), .credit_count(credit_count),
		.link_up(link_up)
	);

endmodule

//--- design/bridge_ctrl.sv
`timescale 1ns/1ps
`include "bridge_macros.svh"

module bridge_ctrl import bridge_pkg::*; (
	input  logic                            sysclk,
	input  logic                            rst,

	//APB completer
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [`BRIDGE_ADDR_WIDTH-1:0]   paddr,
	input  logic [`BRIDGE_DATA_WIDTH-1:0]   pwdata,
	output logic [`BRIDGE_DATA_WIDTH-1:0]   prdata,
	output logic                            pready,
	output logic                            pslverr,

	//To frame_tx
	output logic                            tx_start,
	output apb_op_t                         tx_op,
	output logic [`BRIDGE_ADDR_WIDTH-1:0]   tx_addr,
	output logic [`BRIDGE_DATA_WIDTH-1:0]   tx_wdata,
	input  logic                            tx_busy,

	//From frame_rx
	input  logic                            resp_valid,
	input  resp_status_t                    resp_status,
	input  logic [`BRIDGE_DATA_WIDTH-1:0]   resp_rdata,
	input  logic                            credit_valid,
	input  logic [`BRIDGE_CREDIT_WIDTH-1:0] credit_count
);

	localparam int CW = `BRIDGE_CREDIT_WIDTH;
	localparam logic [CW-1:0] CREDIT_CAP = CW'(`BRIDGE_CREDITS_MAX);
	localparam int TIMER_W = $clog2(`BRIDGE_READ_TIMEOUT);
	//pready is registered, so stop one count early
	localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(`BRIDGE_READ_TIMEOUT - 2);

	ctrl_state_t        state;
	logic [CW-1:0]      credits;
	logic [CW:0]        credit_sum;	//One spare bit before saturation
	logic [TIMER_W-1:0] timer;		//Cycles since read EOF left
	logic               access;
	logic               consume;
	logic               timeout;

	assign access  = psel && penable;
	assign consume = (state == CS_WAIT_CREDIT) && (credits != '0) && !tx_busy;
	assign timeout = (state == CS_WAIT_RESP) && !tx_busy && (timer == TIMER_LAST);

	////////////////////////////////////////////////////////////
	// Credit accounting

	always_comb begin
		credit_sum = {1'b0, credits} - {{CW{1'b0}}, consume};
		if (credit_valid)
			credit_sum = credit_sum + {1'b0, credit_count};
	end

	////////////////////////////////////////////////////////////
	// Completer FSM

	always_ff @(posedge sysclk) begin
		if (rst) begin
			state    <= CS_IDLE;
			credits  <= '0;
			timer    <= '0;
			tx_start <= 1'b0;
			pready   <= 1'b0;
			pslverr  <= 1'b0;
		end else begin
			credits  <= (credit_sum > {1'b0, CREDIT_CAP}) ? CREDIT_CAP : credit_sum[CW-1:0];
			tx_start <= 1'b0;
			case (state)
				CS_IDLE: if (access) state <= CS_WAIT_CREDIT;
				CS_WAIT_CREDIT: begin
					if (consume) begin
						tx_start <= 1'b1;
						state    <= CS_SEND;
					end
				end
				CS_SEND: begin
					timer <= '0;
					if (tx_op == OP_WRITE) begin	//Posted, done now
						pready  <= 1'b1;
						pslverr <= 1'b0;
						state   <= CS_DONE;
					end else
						state <= CS_WAIT_RESP;
				end
				CS_WAIT_RESP: begin
					if (!tx_busy)
						timer <= timer + 1'b1;	//Start once EOF is out
					if (resp_valid || timeout) begin
						pready  <= 1'b1;
						pslverr <= timeout || (resp_status != RESP_OK);
						state   <= CS_DONE;
					end
				end
				default: begin	//Access completes this cycle
					pready <= 1'b0;
					state  <= CS_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge sysclk) begin
		if (state == CS_IDLE && access) begin
			tx_op    <= pwrite ? OP_WRITE : OP_READ;
			tx_addr  <= paddr;
			tx_wdata <= pwrite ? pwdata : '0;
		end
		if (state == CS_WAIT_RESP && resp_valid)
			prdata <= resp_rdata;
		else if (timeout)
			prdata <= '0;
	end

	a_credit_cap: assert property (@(posedge sysclk) disable iff (rst) credits <= CREDIT_CAP);

	//Manager holds the access phase until pready
	a_ready_access: assert property (@(posedge sysclk) disable iff (rst) pready |-> access);

endmodule

//--- design/frame_rx.sv
`timescale 1ns/1ps
`include "bridge_macros.svh"

module frame_rx import bridge_pkg::*, lane_pkg::*; (
	input  logic                           sysclk,
	input  logic                           rst,

	//Receive lane
	input  logic [`BRIDGE_DATA_WIDTH-1:0]  rx_data,
	input  logic [`LANE_K_WIDTH-1:0]       rx_char_is_k,
	input  logic                           rx_comma_is_aligned,

	//Decoded traffic toward bridge_ctrl
	output logic                           resp_valid,
	output resp_status_t                   resp_status,
	output logic [`BRIDGE_DATA_WIDTH-1:0]  resp_rdata,
	output logic                           credit_valid,
	output logic [`BRIDGE_CREDIT_WIDTH-1:0] credit_count,
	output logic                           link_up
);

	rx_state_t                     state;
	frame_pos_t                    expect_pos;
	logic                          word_ok;	//Word fits current position
	logic                          is_credit;
	logic                          is_idle;
	resp_status_t                  status_q;
	logic [`BRIDGE_DATA_WIDTH-1:0] rdata_q;
	logic                          crc_en;
	logic [`BRIDGE_DATA_WIDTH-1:0] crc_word;
	logic [`BRIDGE_BYTE_WIDTH-1:0] crc;

	function automatic logic word_matches(input frame_pos_t p, input logic [31:0] d,
		input logic [3:0] k);
		case (p)
			FP_SOF:  return (k == `LANE_K_CTRL) && (d[7:0] == `LANE_K_SOF);
			FP_DATA: return (k == 4'b0000);
			default: return (k == `LANE_K_CTRL) && (d[7:0] == `LANE_K_EOF);
		endcase
	endfunction

	always_comb begin
		case (state)
			RX_DATA: expect_pos = FP_DATA;
			RX_EOF:  expect_pos = FP_EOF;
			default: expect_pos = FP_SOF;
		endcase
	end

	assign word_ok   = rx_comma_is_aligned && word_matches(expect_pos, rx_data, rx_char_is_k);
	assign is_credit = rx_comma_is_aligned && state == RX_HUNT &&
		rx_char_is_k == `LANE_K_CTRL && rx_data[7:0] == `LANE_K_CREDIT;
	assign is_idle   = rx_comma_is_aligned &&
		rx_char_is_k == `LANE_K_CTRL && rx_data[7:0] == `LANE_K_IDLE;

	////////////////////////////////////////////////////////////
	// CRC check, K byte of SOF taken as zero

	assign crc_en   = word_ok && state != RX_EOF;
	assign crc_word = (state == RX_HUNT) ? {rx_data[31:8], 8'h00} : rx_data;

	lane_crc crc_chk (
		.sysclk(sysclk),
		.rst(rst),
		.clear(state == RX_HUNT),
		.en(crc_en),
		.word(crc_word),
		.crc(crc)
	);

	////////////////////////////////////////////////////////////
	// Parser and link status

	always_ff @(posedge sysclk) begin
		if (rst) begin
			state        <= RX_HUNT;
			resp_valid   <= 1'b0;
			credit_valid <= 1'b0;
			link_up      <= 1'b0;
		end else begin
			resp_valid   <= 1'b0;		//Single cycle pulses
			credit_valid <= is_credit;
			if (!rx_comma_is_aligned) begin
				state   <= RX_HUNT;	//Partial frame dropped
				link_up <= 1'b0;
			end else begin
				if (is_idle)
					link_up <= 1'b1;
				case (state)
					RX_HUNT: if (word_ok) state <= RX_DATA;
					RX_DATA: state <= word_ok ? RX_EOF : RX_HUNT;
					default: begin
						state      <= RX_HUNT;
						resp_valid <= word_ok;
					end
				endcase
			end
		end
	end

	always_ff @(posedge sysclk) begin
		if (state == RX_HUNT && word_ok)
			status_q <= resp_status_t'(rx_data[15:8]);
		if (state == RX_DATA)
			rdata_q <= rx_data;
		if (is_credit)
			credit_count <= rx_data[10:8];	//1 to 4
		if (state == RX_EOF && word_ok) begin
			if (rx_data[15:8] == crc) begin
				resp_status <= status_q;
				resp_rdata  <= rdata_q;
			end else begin
				resp_status <= RESP_CRC;	//Data not trusted
				resp_rdata  <= '0;
			end
		end
	end

	a_one_pulse: assert property (@(posedge sysclk) disable iff (rst)
		!(resp_valid && credit_valid));

	//Far end returns 1 to BRIDGE_CREDITS_MAX per credit word
	a_credit_range: assert property (@(posedge sysclk) disable iff (rst)
		credit_valid |-> (credit_count != '0 && credit_count <= `BRIDGE_CREDITS_MAX));

endmodule

//--- design/frame_tx.sv
`timescale 1ns/1ps
`include "bridge_macros.svh"

module frame_tx import bridge_pkg::*, lane_pkg::*; (
	input  logic                          sysclk,
	input  logic                          rst,

	//Request from bridge_ctrl
	input  logic                          tx_start,
	input  apb_op_t                       tx_op,
	input  logic [`BRIDGE_ADDR_WIDTH-1:0] tx_addr,
	input  logic [`BRIDGE_DATA_WIDTH-1:0] tx_wdata,
	output logic                          tx_busy,	//SOF through EOF on lane

	//Transmit lane
	output logic [`BRIDGE_DATA_WIDTH-1:0] tx_data,
	output logic [`LANE_K_WIDTH-1:0]      tx_char_is_k
);

	frame_pos_t                    pos;		//Next word to register
	logic [`BRIDGE_DATA_WIDTH-1:0] wdata_q;
	logic [`BRIDGE_DATA_WIDTH-1:0] sof_body;	//SOF with K byte zeroed
	logic [`BRIDGE_DATA_WIDTH-1:0] crc_word;
	logic                          crc_en;
	logic [`BRIDGE_BYTE_WIDTH-1:0] crc;

	//Address zero extended into the upper half
	assign sof_body = {{(16 - `BRIDGE_ADDR_WIDTH){1'b0}}, tx_addr, tx_op, 8'h00};

	////////////////////////////////////////////////////////////
	// CRC over SOF body then data word

	assign crc_en   = tx_start || (tx_busy && pos == FP_DATA);
	assign crc_word = tx_start ? sof_body : wdata_q;

	lane_crc crc_gen (
		.sysclk(sysclk),
		.rst(rst),
		.clear(tx_start),
		.en(crc_en),
		.word(crc_word),
		.crc(crc)
	);

	////////////////////////////////////////////////////////////
	// Lane word sequencer

	always_ff @(posedge sysclk) begin
		if (tx_start)
			wdata_q <= tx_wdata;	//Read frames carry zero from ctrl
	end

	always_ff @(posedge sysclk) begin
		if (rst) begin
			tx_busy      <= 1'b0;
			pos          <= FP_SOF;
			tx_data      <= `LANE_IDLE_WORD;
			tx_char_is_k <= `LANE_K_CTRL;
		end else if (tx_start) begin
			tx_busy      <= 1'b1;
			pos          <= FP_DATA;
			tx_data      <= {sof_body[31:8], `LANE_K_SOF};
			tx_char_is_k <= `LANE_K_CTRL;
		end else if (tx_busy) begin
			case (pos)
				FP_DATA: begin
					pos          <= FP_EOF;
					tx_data      <= wdata_q;
					tx_char_is_k <= '0;	//Plain data
				end
				FP_EOF: begin
					pos          <= FP_SOF;
					tx_data      <= {16'h0000, crc, `LANE_K_EOF};
					tx_char_is_k <= `LANE_K_CTRL;
				end
				default: begin	//EOF now on lane
					tx_busy      <= 1'b0;
					tx_data      <= `LANE_IDLE_WORD;
					tx_char_is_k <= `LANE_K_CTRL;
				end
			endcase
		end
	end

	//Ctrl must wait for the lane to free up
	a_start_idle: assert property (@(posedge sysclk) disable iff (rst) tx_busy |-> !tx_start);

	//EOF lands three cycles after the start pulse
	a_eof_slot: assert property (@(posedge sysclk) disable iff (rst)
		tx_start |-> ##3 (tx_char_is_k == `LANE_K_CTRL && tx_data[7:0] == `LANE_K_EOF));

endmodule

//--- design/lane_crc.sv
`timescale 1ns/1ps
`include "bridge_macros.svh"

module lane_crc (
	input  logic                          sysclk,
	input  logic                          rst,
	input  logic                          clear,	//Restart from zero
	input  logic                          en,		//Fold in word this cycle
	input  logic [`BRIDGE_DATA_WIDTH-1:0] word,
	output logic [`BRIDGE_BYTE_WIDTH-1:0] crc		//Includes current word
);

	logic [`BRIDGE_BYTE_WIDTH-1:0] crc_q;
	logic [`BRIDGE_BYTE_WIDTH-1:0] crc_base;
	logic [`BRIDGE_BYTE_WIDTH-1:0] crc_next;

	//One byte, MSB first, no reflection
	function automatic logic [7:0] crc_byte(input logic [7:0] c_in, input logic [7:0] b);
		logic [7:0] c;
		c = c_in ^ b;
		for (int i = 0; i < 8; i++) begin
			c = c[7] ? ((c << 1) ^ `LANE_CRC_POLY) : (c << 1);
		end
		return c;
	endfunction

	always_comb begin
		crc_base = clear ? 8'h00 : crc_q;	//clear with en starts on this word
		crc_next = crc_base;
		for (int i = 0; i < `BRIDGE_DATA_WIDTH / 8; i++) begin
			crc_next = crc_byte(crc_next, word[8*i +: 8]);	//LSB byte first
		end
		crc = en ? crc_next : crc_base;
	end

	always_ff @(posedge sysclk) begin
		if (rst)
			crc_q <= 8'h00;
		else
			crc_q <= crc;
	end

endmodule

//--- design/lane_pkg.sv
package lane_pkg;

	////////////////////////////////////////////////////////////
	// Word position inside a frame
	//
	// Every frame is SOF, one data word, EOF on back to back
	// cycles. Both directions use the same layout

	typedef enum logic [1:0] {
		FP_SOF,		//K27.7 in LSB, op or status, address
		FP_DATA,	//Payload, no K flags
		FP_EOF		//K29.7 in LSB, CRC in byte1
	} frame_pos_t;

	////////////////////////////////////////////////////////////
	// Receive parser

	//Hunt also picks up credit and idle words
	typedef enum logic [1:0] {
		RX_HUNT,	//Looking for SOF
		RX_DATA,	//Expecting the data word
		RX_EOF		//Expecting EOF and CRC
	} rx_state_t;

	//Any word out of place sends the parser
	//back to RX_HUNT and the partial frame is lost

endpackage

//--- design/bridge_pkg.sv
`include "bridge_macros.svh"

package bridge_pkg;

	////////////////////////////////////////////////////////////
	// Request opcode, sent as byte1 of the SOF word

	typedef enum logic [`BRIDGE_BYTE_WIDTH-1:0] {
		OP_READ  = 8'h01,
		OP_WRITE = 8'h02
	} apb_op_t;

	////////////////////////////////////////////////////////////
	// Response status, byte1 of the response SOF word

	typedef enum logic [`BRIDGE_BYTE_WIDTH-1:0] {
		RESP_OK  = 8'h00,	//Completed normally
		RESP_ERR = 8'h01,	//Far end flagged an error
		RESP_CRC = 8'h02	//Local CRC check failed
	} resp_status_t;

	////////////////////////////////////////////////////////////
	// APB completer FSM

	typedef enum logic [2:0] {
		CS_IDLE,		//Waiting for access phase
		CS_WAIT_CREDIT,	//Need a credit and a free transmitter
		CS_SEND,		//Frame just started
		CS_WAIT_RESP,	//Read outstanding
		CS_DONE		//pready high this cycle
	} ctrl_state_t;

endpackage

//--- design/bridge_macros.svh
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

////////////////////////////////////////////////////////////
// APB side widths

`define BRIDGE_ADDR_WIDTH	10	//Management address space
`define BRIDGE_DATA_WIDTH	32	//APB data and lane word
`define BRIDGE_BYTE_WIDTH	8	//Opcode, status and CRC fields

////////////////////////////////////////////////////////////
// Flow control and timeout

`define BRIDGE_CREDIT_WIDTH	3	//Holds 0 to BRIDGE_CREDITS_MAX
`define BRIDGE_CREDITS_MAX	4	//Far end buffer depth
`define BRIDGE_READ_TIMEOUT	64	//Cycles after read EOF

////////////////////////////////////////////////////////////
// Lane characters

`define LANE_K_WIDTH		4		//One K flag per byte
`define LANE_K_CTRL		4'b0001	//K char in LSB only

//K28.5 comma, also the idle marker
`define LANE_K_IDLE		8'hbc
`define LANE_K_SOF		8'hfb	//K27.7
`define LANE_K_EOF		8'hfd	//K29.7
`define LANE_K_CREDIT		8'h5c	//K28.2

//K28.5 D21.5 D0.0 D0.0, comma in LSB
`define LANE_IDLE_WORD		32'h0000b5bc

`define LANE_CRC_POLY		8'h07	//x^8 + x^2 + x + 1

`endif
